/* verilog/mat_pkg.sv */
// ==============================
// Weight matrix geometry for a single fixed shape. Elements are signed
// Q8.8 fixed point. Nothing here does arithmetic on the format.
// ==============================
package mat_pkg;

    // Element format
    localparam int elem_width = 16;
    localparam int frac_width = 8;

    // Matrix shape
    localparam int mat_rows = 8;
    localparam int mat_cols = 8;

    // One RAM word per matrix row
    localparam int row_addr_width = $clog2(mat_rows);

    // One signed fixed-point weight
    typedef logic signed [elem_width-1:0] elem_t;

    // Full matrix row with element 0 as column 0
    typedef elem_t [mat_cols-1:0] w_row_t;

endpackage

/* verilog/n2r_pkg.sv */
// ==============================
// Reorder constants for 2x2 vertical blocks. Matrix dimensions must
// divide evenly by the block size and give power-of-two counts.
// ==============================
package n2r_pkg;

    import mat_pkg::*;

    // Block shape
    localparam int block_rows = 2;
    localparam int block_cols = 2;

    // Block counts with row blocks running inner
    localparam int total_row_blocks = mat_rows / block_rows;
    localparam int col_groups       = mat_cols / block_cols;
    localparam int total_blocks     = total_row_blocks * col_groups;

    // Index widths for the block counter
    localparam int rb_width      = $clog2(total_row_blocks);
    localparam int cg_width      = $clog2(col_groups);
    localparam int blk_cnt_width = $clog2(total_blocks) + 1;

    typedef enum logic [1:0] {
        idle  = 2'd0,
        fill  = 2'd1,
        slice = 2'd2,
        done  = 2'd3
    } n2r_state_e;

    // Top is the even row of the pair, left the even column
    typedef struct packed {
        elem_t top_left;
        elem_t bottom_left;
        elem_t top_right;
        elem_t bottom_right;
    } w_block_t;

    typedef struct packed {
        logic output_ready;
        logic slice_done;
        logic buffer_done;
    } n2r_status_t;

endpackage

/* verilog/ram_1w2r.sv */
`timescale 1ns/1ps
// ==============================
// Register-array RAM, one write and two registered read ports.
// A read of the address being written returns the old word.
// ==============================
module ram_1w2r
    import mat_pkg::*;
#(
    parameter type word_t = w_row_t
) (
    input  logic                      clk,
    input  logic                      we,
    input  logic [row_addr_width-1:0] waddr,
    input  word_t                     wdata,
    input  logic [row_addr_width-1:0] raddr0,
    input  logic [row_addr_width-1:0] raddr1,
    output word_t                     rdata0,
    output word_t                     rdata1
);

    word_t mem [mat_rows];

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Both read ports sample every cycle
    always_ff @(posedge clk) begin
        rdata0 <= mem[raddr0];
        rdata1 <= mem[raddr1];
    end

endmodule

/* verilog/n2r_buffer_w.sv */
`timescale 1ns/1ps
// ==============================
// Fills once from row-major rows, then emits one 2x2 block per cycle,
// 3 cycles after entering slice. Stays done until rst_n.
// ==============================
module n2r_buffer_w
    import mat_pkg::*;
    import n2r_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  w_row_t      row_in,
    output w_block_t    block_out,
    output n2r_status_t status
);

    n2r_state_e state_reg;
    n2r_state_e state_next;

    // Fill side
    logic [row_addr_width-1:0] row_cnt;
    logic                      ram_we;
    logic                      fill_last;

    // Block issue, stage 0
    logic [blk_cnt_width-1:0]  blk_cnt;
    logic [rb_width-1:0]       row_blk;
    logic [cg_width-1:0]       col_grp;
    logic                      issue;
    logic                      issue_last;

    // Address register, stage 1
    logic [row_addr_width-1:0] raddr0;
    logic [row_addr_width-1:0] raddr1;
    logic [cg_width-1:0]       col_d1;
    logic                      vld_d1;
    logic                      last_d1;

    // RAM output, stage 2
    w_row_t                    rdata0;
    w_row_t                    rdata1;
    logic [cg_width-1:0]       col_d2;
    logic                      vld_d2;
    logic                      last_d2;

    // Output register, stage 3
    w_block_t                  block_next;
    logic                      out_vld;
    logic                      out_last;

    // FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_reg <= idle;
        end else begin
            state_reg <= state_next;
        end
    end

    always_comb begin
        state_next = state_reg;
        case (state_reg)
            idle: begin
                if (en) begin
                    state_next = fill;
                end
            end
            fill: begin
                if (fill_last) begin
                    state_next = slice;
                end
            end
            // Leave slice only once the last block has left the pipe
            slice: begin
                if (out_last) begin
                    state_next = done;
                end
            end
            done:    state_next = done;
            default: state_next = idle;
        endcase
    end

    // Row write and counter
    assign ram_we    = (state_reg == fill) && en;
    assign fill_last = ram_we && (row_cnt == row_addr_width'(mat_rows - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_cnt <= '0;
        end else if (ram_we) begin
            row_cnt <= row_cnt + 1'b1;
        end
    end

    // Block counter stops at total_blocks
    assign issue      = (state_reg == slice) && (blk_cnt < blk_cnt_width'(total_blocks));
    assign issue_last = issue && (blk_cnt == blk_cnt_width'(total_blocks - 1));
    assign row_blk    = blk_cnt[rb_width-1:0];
    assign col_grp    = blk_cnt[rb_width +: cg_width];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            blk_cnt <= '0;
        end else if (issue) begin
            blk_cnt <= blk_cnt + 1'b1;
        end
    end

    // Row-pair addresses and column group alongside the RAM latency
    always_ff @(posedge clk) begin
        raddr0 <= row_addr_width'(row_blk * block_rows);
        raddr1 <= row_addr_width'(row_blk * block_rows + 1);
        col_d1 <= col_grp;
        col_d2 <= col_d1;
    end

    // Valid and last markers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_d1   <= 1'b0;
            last_d1  <= 1'b0;
            vld_d2   <= 1'b0;
            last_d2  <= 1'b0;
            out_vld  <= 1'b0;
            out_last <= 1'b0;
        end else begin
            vld_d1   <= issue;
            last_d1  <= issue_last;
            vld_d2   <= vld_d1;
            last_d2  <= last_d1;
            out_vld  <= vld_d2;
            out_last <= last_d2;
        end
    end

    // Pick the column pair out of both rows
    always_comb begin
        block_next.top_left     = rdata0[col_d2 * block_cols];
        block_next.bottom_left  = rdata1[col_d2 * block_cols];
        block_next.top_right    = rdata0[col_d2 * block_cols + 1];
        block_next.bottom_right = rdata1[col_d2 * block_cols + 1];
    end

    always_ff @(posedge clk) begin
        if (vld_d2) begin
            block_out <= block_next;
        end
    end

    assign status.output_ready = out_vld;
    assign status.slice_done   = out_last;
    assign status.buffer_done  = (state_reg == done);

    ram_1w2r #(
        .word_t (w_row_t)
    ) u_ram (
        .clk    (clk),
        .we     (ram_we),
        .waddr  (row_cnt),
        .wdata  (row_in),
        .raddr0 (raddr0),
        .raddr1 (raddr1),
        .rdata0 (rdata0),
        .rdata1 (rdata1)
    );

endmodule

/* verilog/n2r_weight_top.sv */
`timescale 1ns/1ps
// ==============================
// Weight-side reorder subsystem. One fill per reset, no back-pressure
// on block_out while status.output_ready is high.
// ==============================
module n2r_weight_top
    import mat_pkg::*;
    import n2r_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  w_row_t      row_in,
    output w_block_t    block_out,
    output n2r_status_t status
);

    n2r_buffer_w u_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .row_in    (row_in),
        .block_out (block_out),
        .status    (status)
    );

endmodule

/* verification/n2r_checker.sv */
`timescale 1ns/1ps
// ==============================
// Status protocol assertions bound into n2r_buffer_w
// ==============================
module n2r_checker
    import n2r_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input n2r_status_t status
);

    // Count of failed assertions
    int assert_fails = 0;

    // Last block flag only comes with a valid block
    last_with_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        status.slice_done |-> status.output_ready
    ) else begin
        $error("slice_done high while output_ready is low");
        assert_fails++;
    end

    no_block_when_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        status.buffer_done |-> !status.output_ready
    ) else begin
        $error("output_ready high while buffer_done is high");
        assert_fails++;
    end

    // Done holds until the next reset
    done_is_sticky: assert property (
        @(posedge clk) disable iff (!rst_n)
        status.buffer_done |=> status.buffer_done
    ) else begin
        $error("buffer_done dropped without a reset");
        assert_fails++;
    end

    clear_after_reset: assert property (
        @(posedge clk)
        !rst_n |=> (status == '0)
    ) else begin
        $error("status not all low in the cycle after reset");
        assert_fails++;
    end

endmodule

bind n2r_buffer_w n2r_checker u_checker (
    .clk    (clk),
    .rst_n  (rst_n),
    .status (status)
);

/* verification/n2r_tb.sv */
`timescale 1ns/1ps
// ==============================
// Directed tests for the weight reorder buffer. No refill in the DUT,
// so every test starts with its own reset.
// ==============================
module n2r_tb
    import mat_pkg::*;
    import n2r_pkg::*;
();

    logic        clk;
    logic        rst_n;
    logic        en;
    w_row_t      row_in;
    w_block_t    block_out;
    n2r_status_t status;

    // Matrix written in the current test
    w_row_t mat [mat_rows];

    int error_count;
    int test_count;

    n2r_weight_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .row_in    (row_in),
        .block_out (block_out),
        .status    (status)
    );

    always #4 clk = ~clk;

    // Each test gets reset, a gapped fill and 30 cycles of output
    initial begin : watchdog
        int limit_ns;
        limit_ns = 6 * (3 + 4 * mat_rows + 30) * 8;
        #(limit_ns);
        $display("Timeout: tests still running after %0d ns", limit_ns);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        next_cycle();
        rst_n  = 1'b0;
        en     = 1'b0;
        row_in = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    function automatic w_row_t random_row();
        w_row_t row;
        int     c;
        for (c = 0; c < mat_cols; c++) begin
            row[c] = elem_t'($urandom());
        end
        return row;
    endfunction

    function automatic n2r_status_t make_status(input logic rdy, input logic sd, input logic bd);
        n2r_status_t s;
        s.output_ready = rdy;
        s.slice_done   = sd;
        s.buffer_done  = bd;
        return s;
    endfunction

    // Row block inner, column group outer
    function automatic w_block_t model_block(input int k);
        w_block_t b;
        int       r;
        int       c;
        r = (k % total_row_blocks) * block_rows;
        c = (k / total_row_blocks) * block_cols;
        b.top_left     = mat[r][c];
        b.bottom_left  = mat[r + 1][c];
        b.top_right    = mat[r][c + 1];
        b.bottom_right = mat[r + 1][c + 1];
        return b;
    endfunction

    task automatic compare_block(input w_block_t expected, input int idx);
        if (block_out !== expected) begin
            $display("ERROR: block_out[%0d] expected 0x%h got 0x%h", idx, expected, block_out);
            error_count++;
        end
    endtask

    task automatic compare_status(input n2r_status_t expected, input string what);
        if (status !== expected) begin
            $display("ERROR: status (%s) expected 0x%h got 0x%h", what, expected, status);
            error_count++;
        end
    endtask

    task automatic fill_random_matrix();
        int r;
        for (r = 0; r < mat_rows; r++) begin
            mat[r] = random_row();
        end
    endtask

    // Row index in the high nibble, column index in the low nibble
    task automatic fill_index_pattern();
        int r;
        int c;
        for (r = 0; r < mat_rows; r++) begin
            for (c = 0; c < mat_cols; c++) begin
                mat[r][c] = elem_t'(r * 16 + c);
            end
        end
    endtask

    // Start cycle, then each row after up to max_gap idle cycles carrying junk
    task automatic load_matrix(input int max_gap);
        int r;
        int gap;
        next_cycle();
        en     = 1'b1;
        row_in = random_row();
        for (r = 0; r < mat_rows; r++) begin
            gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
            repeat (gap) begin
                next_cycle();
                en     = 1'b0;
                row_in = random_row();
            end
            next_cycle();
            en     = 1'b1;
            row_in = mat[r];
        end
        // The edge that writes the last row also enters slice
        next_cycle();
        en     = 1'b0;
        row_in = random_row();
    endtask

    // Latency counts edges from slice entry to the first block
    task automatic collect_blocks(output int latency);
        int k;
        latency = 0;
        while (!status.output_ready && latency < 40) begin
            next_cycle();
            latency++;
        end
        if (!status.output_ready) begin
            $display("No block appeared within 40 cycles after the fill");
            error_count++;
        end else begin
            for (k = 0; k < total_blocks; k++) begin
                compare_status(make_status(1'b1, k == total_blocks - 1, 1'b0), "block stream");
                compare_block(model_block(k), k);
                next_cycle();
            end
            compare_status(make_status(1'b0, 1'b0, 1'b1), "after last block");
        end
    endtask

    task automatic idle_after_reset();
        test_count++;
        apply_reset();
        compare_status(make_status(1'b0, 1'b0, 1'b0), "after reset");
        repeat (10) begin
            next_cycle();
            compare_status(make_status(1'b0, 1'b0, 1'b0), "idle with en low");
        end
    endtask

    task automatic full_slice_order();
        int latency;
        test_count++;
        apply_reset();
        fill_random_matrix();
        load_matrix(0);
        collect_blocks(latency);
    endtask

    task automatic gapped_fill();
        int latency;
        test_count++;
        apply_reset();
        fill_random_matrix();
        load_matrix(2);
        collect_blocks(latency);
    endtask

    task automatic completion_timing();
        int latency;
        test_count++;
        apply_reset();
        fill_random_matrix();
        load_matrix(0);
        collect_blocks(latency);
        // 3 edges after slice entry, 4 after the last row is presented
        if (latency != 3) begin
            $display("ERROR: output_ready latency expected 0x%h got 0x%h", 3, latency);
            error_count++;
        end
        repeat (5) begin
            next_cycle();
            compare_status(make_status(1'b0, 1'b0, 1'b1), "done held");
        end
    endtask

    task automatic no_restart_in_done();
        int latency;
        int i;
        test_count++;
        apply_reset();
        fill_random_matrix();
        load_matrix(0);
        collect_blocks(latency);
        for (i = 0; i < 3; i++) begin
            en     = 1'b1;
            row_in = random_row();
            next_cycle();
            compare_status(make_status(1'b0, 1'b0, 1'b1), "en pulse in done");
            en = 1'b0;
            next_cycle();
            compare_status(make_status(1'b0, 1'b0, 1'b1), "after en pulse in done");
        end
        repeat (6) begin
            next_cycle();
            compare_status(make_status(1'b0, 1'b0, 1'b1), "done after late en");
        end
    endtask

    task automatic distinct_value_fields();
        int latency;
        test_count++;
        apply_reset();
        fill_index_pattern();
        load_matrix(0);
        collect_blocks(latency);
    endtask

    initial begin
        int assert_fails;
        clk         = 1'b0;
        rst_n       = 1'b0;
        en          = 1'b0;
        row_in      = '0;
        error_count = 0;
        test_count  = 0;
        void'($urandom(70933));

        idle_after_reset();
        full_slice_order();
        gapped_fill();
        completion_timing();
        no_restart_in_done();
        distinct_value_fields();

        assert_fails = dut.u_buffer.u_checker.assert_fails;
        $display("Tests: %0d, check errors: %0d, assertion failures: %0d",
                 test_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* filelist.f */
verilog/mat_pkg.sv
verilog/n2r_pkg.sv
verilog/ram_1w2r.sv
verilog/n2r_buffer_w.sv
verilog/n2r_weight_top.sv
verification/n2r_checker.sv
verification/n2r_tb.sv

/* Bender.yml */
package:
  name: n2r_weight

sources:
  # Design sources, compiled in every target
  - files:
      - verilog/mat_pkg.sv
      - verilog/n2r_pkg.sv
      - verilog/ram_1w2r.sv
      - verilog/n2r_buffer_w.sv
      - verilog/n2r_weight_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verification/n2r_checker.sv
      - verification/n2r_tb.sv
